//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int SHAMT_W    = 5;
    localparam int FUNC_W     = 6;
    localparam int IMM_W      = 16;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WORD_W-1:0]     inst_t;

    // lsb position of each instruction field
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNC_LSB  = 0;
    localparam int IMM_LSB   = 0;

    localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_ADDI    = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
    localparam logic [OPCODE_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_SLTIU   = 6'b001011;
    localparam logic [OPCODE_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [OPCODE_W-1:0] OP_LUI     = 6'b001111;

    localparam logic [FUNC_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNC_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNC_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNC_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [FUNC_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [FUNC_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [FUNC_W-1:0] FN_MOVZ = 6'b001010;
    localparam logic [FUNC_W-1:0] FN_MOVN = 6'b001011;
    localparam logic [FUNC_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [FUNC_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNC_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [FUNC_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNC_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNC_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNC_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNC_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNC_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNC_W-1:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

//--- hw/uop_pkg.sv
`default_nettype none

package uop_pkg;

    localparam int ALU_OP_W = 4;

    // each op also fixes its result group (logic, shift, arith, move)
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_OR   = 4'd0,
        ALU_AND  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_NOR  = 4'd3,
        ALU_SLL  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SRA  = 4'd6,
        ALU_ADD  = 4'd7,   // also addi
        ALU_ADDU = 4'd8,   // also addiu
        ALU_SUB  = 4'd9,
        ALU_SUBU = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SLTU = 4'd12,
        ALU_MOVE = 4'd13   // movn / movz, passes operand 1
    } alu_op_e;

endpackage

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import isa_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [1:NUM_REGS-1]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    assign rdata1_o = (raddr1_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr1_i)   ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr2_i)   ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode import isa_pkg::*, uop_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  word_t     rf_rdata1_i,
    input  word_t     rf_rdata2_i,
    input  logic      ex_fwd_wen_i,
    input  reg_addr_t ex_fwd_addr_i,
    input  word_t     ex_fwd_data_i,
    input  logic      ex_wen_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    output reg_addr_t rf_raddr1_o,
    output reg_addr_t rf_raddr2_o,
    output logic      de_valid_o,
    output alu_op_e   de_op_o,
    output word_t     de_opnd1_o,
    output word_t     de_opnd2_o,
    output reg_addr_t de_waddr_o,
    output logic      de_wen_o
);

    logic [OPCODE_W-1:0] op;
    reg_addr_t           rs;
    reg_addr_t           rt;
    reg_addr_t           rd;
    logic [SHAMT_W-1:0]  shamt;
    logic [FUNC_W-1:0]   func;
    logic [IMM_W-1:0]    imm16;

    alu_op_e   op_c;
    word_t     imm_c;
    reg_addr_t waddr_c;
    logic      valid_c;     // known encoding
    logic      use_imm_c;   // operand 2 from immediate
    logic      use_shamt_c; // operand 1 from shamt field
    logic      zero1_c;     // operand 1 forced to zero (lui)
    logic      is_movn_c;
    logic      is_movz_c;
    logic      wen_c;
    word_t     rs_val;
    word_t     rt_val;

    assign op    = inst_i[OP_LSB +: OPCODE_W];
    assign rs    = inst_i[RS_LSB +: REG_ADDR_W];
    assign rt    = inst_i[RT_LSB +: REG_ADDR_W];
    assign rd    = inst_i[RD_LSB +: REG_ADDR_W];
    assign shamt = inst_i[SHAMT_LSB +: SHAMT_W];
    assign func  = inst_i[FUNC_LSB +: FUNC_W];
    assign imm16 = inst_i[IMM_LSB +: IMM_W];

    assign rf_raddr1_o = rs;
    assign rf_raddr2_o = rt;

    // execute result wins, then execute register, then regfile
    assign rs_val = (ex_fwd_wen_i && ex_fwd_addr_i == rs) ? ex_fwd_data_i :
                    (ex_wen_i && ex_waddr_i == rs)        ? ex_wdata_i    : rf_rdata1_i;
    assign rt_val = (ex_fwd_wen_i && ex_fwd_addr_i == rt) ? ex_fwd_data_i :
                    (ex_wen_i && ex_waddr_i == rt)        ? ex_wdata_i    : rf_rdata2_i;

    always_comb begin
        op_c        = ALU_OR;
        imm_c       = '0;
        waddr_c     = rt;
        valid_c     = 1'b1;
        use_imm_c   = 1'b1;
        use_shamt_c = 1'b0;
        zero1_c     = 1'b0;
        is_movn_c   = 1'b0;
        is_movz_c   = 1'b0;
        case (op)
            OP_SPECIAL: begin
                waddr_c   = rd;
                use_imm_c = 1'b0;
                valid_c   = (shamt == '0); // register forms leave shamt empty
                case (func)
                    FN_OR:   op_c = ALU_OR;
                    FN_AND:  op_c = ALU_AND;
                    FN_XOR:  op_c = ALU_XOR;
                    FN_NOR:  op_c = ALU_NOR;
                    FN_SLLV: op_c = ALU_SLL;
                    FN_SRLV: op_c = ALU_SRL;
                    FN_SRAV: op_c = ALU_SRA;
                    FN_ADD:  op_c = ALU_ADD;
                    FN_ADDU: op_c = ALU_ADDU;
                    FN_SUB:  op_c = ALU_SUB;
                    FN_SUBU: op_c = ALU_SUBU;
                    FN_SLT:  op_c = ALU_SLT;
                    FN_SLTU: op_c = ALU_SLTU;
                    FN_MOVN: begin
                        op_c      = ALU_MOVE;
                        is_movn_c = 1'b1;
                    end
                    FN_MOVZ: begin
                        op_c      = ALU_MOVE;
                        is_movz_c = 1'b1;
                    end
                    FN_SLL, FN_SRL, FN_SRA: begin
                        op_c        = (func == FN_SLL) ? ALU_SLL :
                                      (func == FN_SRL) ? ALU_SRL : ALU_SRA;
                        use_shamt_c = 1'b1;
                        valid_c     = (rs == '0); // rs unused, must be zero
                    end
                    default: valid_c = 1'b0;       // mult, sync, hi/lo etc.
                endcase
            end
            OP_ORI:  begin
                op_c  = ALU_OR;
                imm_c = {{(WORD_W-IMM_W){1'b0}}, imm16};
            end
            OP_ANDI: begin
                op_c  = ALU_AND;
                imm_c = {{(WORD_W-IMM_W){1'b0}}, imm16};
            end
            OP_XORI: begin
                op_c  = ALU_XOR;
                imm_c = {{(WORD_W-IMM_W){1'b0}}, imm16};
            end
            OP_LUI:  begin
                op_c    = ALU_OR;
                imm_c   = {imm16, {(WORD_W-IMM_W){1'b0}}};
                zero1_c = 1'b1;
            end
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                op_c  = (op == OP_SLTI)  ? ALU_SLT  :
                        (op == OP_SLTIU) ? ALU_SLTU :
                        (op == OP_ADDI)  ? ALU_ADD  : ALU_ADDU;
                imm_c = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
            end
            default: valid_c = 1'b0;
        endcase
    end

    // move condition is tested on the forwarded rt value
    assign wen_c = valid_c && (waddr_c != '0)
                   && !(is_movn_c && rt_val == '0)
                   && !(is_movz_c && rt_val != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_valid_o <= 1'b0;
            de_wen_o   <= 1'b0;
        end else begin
            de_valid_o <= inst_valid_i;
            de_wen_o   <= inst_valid_i & wen_c;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            de_op_o    <= op_c;
            de_opnd1_o <= use_shamt_c ? {{(WORD_W-SHAMT_W){1'b0}}, shamt} :
                          zero1_c     ? '0 : rs_val;
            de_opnd2_o <= use_imm_c ? imm_c : rt_val;
            de_waddr_o <= waddr_c;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute import isa_pkg::*, uop_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      de_valid_i,
    input  alu_op_e   de_op_i,
    input  word_t     de_opnd1_i,
    input  word_t     de_opnd2_i,
    input  reg_addr_t de_waddr_i,
    input  logic      de_wen_i,
    output logic      ex_fwd_wen_o,
    output reg_addr_t ex_fwd_addr_o,
    output word_t     ex_fwd_data_o,
    output logic      ex_wen_o,
    output reg_addr_t ex_waddr_o,
    output word_t     ex_wdata_o
);

    logic               sub_c;
    word_t              opnd2_eff;
    word_t              sum_c;
    logic               ovf_c;
    logic [SHAMT_W-1:0] sh_amt;
    word_t              result_c;

    assign sub_c     = (de_op_i == ALU_SUB) || (de_op_i == ALU_SUBU);
    assign opnd2_eff = sub_c ? ~de_opnd2_i : de_opnd2_i;
    assign sum_c     = de_opnd1_i + opnd2_eff + {{(WORD_W-1){1'b0}}, sub_c};
    assign sh_amt    = de_opnd1_i[SHAMT_W-1:0];

    // signed overflow only matters for add/addi and sub
    assign ovf_c = ((de_op_i == ALU_ADD) || (de_op_i == ALU_SUB))
                   && (de_opnd1_i[WORD_W-1] == opnd2_eff[WORD_W-1])
                   && (sum_c[WORD_W-1] != de_opnd1_i[WORD_W-1]);

    always_comb begin
        case (de_op_i)
            ALU_OR:   result_c = de_opnd1_i | de_opnd2_i;
            ALU_AND:  result_c = de_opnd1_i & de_opnd2_i;
            ALU_XOR:  result_c = de_opnd1_i ^ de_opnd2_i;
            ALU_NOR:  result_c = ~(de_opnd1_i | de_opnd2_i);
            ALU_SLL:  result_c = de_opnd2_i << sh_amt;
            ALU_SRL:  result_c = de_opnd2_i >> sh_amt;
            ALU_SRA:  result_c = $signed(de_opnd2_i) >>> sh_amt;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU: begin
                result_c = sum_c;
            end
            ALU_SLT:  result_c = {{(WORD_W-1){1'b0}},
                                  ($signed(de_opnd1_i) < $signed(de_opnd2_i))};
            ALU_SLTU: result_c = {{(WORD_W-1){1'b0}}, (de_opnd1_i < de_opnd2_i)};
            ALU_MOVE: result_c = de_opnd1_i; // rs, condition checked in decode
            default:  result_c = '0;
        endcase
    end

    assign ex_fwd_wen_o  = de_valid_i & de_wen_i & ~ovf_c;
    assign ex_fwd_addr_o = de_waddr_i;
    assign ex_fwd_data_o = result_c;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_wen_o <= 1'b0;
        end else begin
            ex_wen_o <= ex_fwd_wen_o;
        end
    end

    always_ff @(posedge clk) begin
        if (de_valid_i) begin
            ex_waddr_o <= de_waddr_i;
            ex_wdata_o <= result_c;
        end
    end

endmodule

`default_nettype wire

//--- hw/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage import isa_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      ex_wen_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    // one write per cycle, seen by regfile and outside alike
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_wen_i) begin
            wb_addr_o <= ex_waddr_i;
            wb_data_o <= ex_wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/int_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top import isa_pkg::*, uop_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;

    logic      de_valid;
    alu_op_e   de_op;
    word_t     de_opnd1;
    word_t     de_opnd2;
    reg_addr_t de_waddr;
    logic      de_wen;

    logic      ex_fwd_wen;   // combinational execute result
    reg_addr_t ex_fwd_addr;
    word_t     ex_fwd_data;
    logic      ex_wen;       // registered execute result
    reg_addr_t ex_waddr;
    word_t     ex_wdata;

    inst_decode u_inst_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .rf_rdata1_i   (rf_rdata1),
        .rf_rdata2_i   (rf_rdata2),
        .ex_fwd_wen_i  (ex_fwd_wen),
        .ex_fwd_addr_i (ex_fwd_addr),
        .ex_fwd_data_i (ex_fwd_data),
        .ex_wen_i      (ex_wen),
        .ex_waddr_i    (ex_waddr),
        .ex_wdata_i    (ex_wdata),
        .rf_raddr1_o   (rf_raddr1),
        .rf_raddr2_o   (rf_raddr2),
        .de_valid_o    (de_valid),
        .de_op_o       (de_op),
        .de_opnd1_o    (de_opnd1),
        .de_opnd2_o    (de_opnd2),
        .de_waddr_o    (de_waddr),
        .de_wen_o      (de_wen)
    );

    alu_execute u_alu_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .de_valid_i    (de_valid),
        .de_op_i       (de_op),
        .de_opnd1_i    (de_opnd1),
        .de_opnd2_i    (de_opnd2),
        .de_waddr_i    (de_waddr),
        .de_wen_i      (de_wen),
        .ex_fwd_wen_o  (ex_fwd_wen),
        .ex_fwd_addr_o (ex_fwd_addr),
        .ex_fwd_data_o (ex_fwd_data),
        .ex_wen_o      (ex_wen),
        .ex_waddr_o    (ex_waddr),
        .ex_wdata_o    (ex_wdata)
    );

    result_stage u_result_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_wen_i   (ex_wen),
        .ex_waddr_i (ex_waddr),
        .ex_wdata_i (ex_wdata),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (wb_valid_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

endmodule

`default_nettype wire

//--- verification/int_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_tb import isa_pkg::*; ;

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    logic      wb_valid_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    // stimulus table with one row per cycle
    inst_t     tbl_inst[$];
    logic      tbl_strobe[$];
    logic      tbl_wen[$];
    reg_addr_t tbl_addr[$];
    word_t     tbl_data[$];

    word_t shadow [NUM_REGS];   // expected architectural state
    int    pending[$];          // rows in flight with the oldest first
    int    cur_row;
    int    mon_row;
    int    nrows;
    int    checked;
    int    errors;
    int    cycles;
    int    max_cycles;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    int_pipe_top u_int_pipe_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    function automatic inst_t rtype_word(input logic [FUNC_W-1:0] fn, input int rd, rs, rt);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic inst_t shift_word(input logic [FUNC_W-1:0] fn, input int rd, rt, sh);
        return {OP_SPECIAL, 5'd0, rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic inst_t itype_word(input logic [OPCODE_W-1:0] op, input int rt, rs, imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // architectural effect of one instruction on the shadow registers
    function automatic void predict_write(input inst_t inst, output logic wen,
                                          output reg_addr_t dst, output word_t val);
        logic [OPCODE_W-1:0] op;
        logic [FUNC_W-1:0]   fn;
        reg_addr_t           rs;
        reg_addr_t           rt;
        logic [SHAMT_W-1:0]  sh;
        logic [IMM_W-1:0]    imm;
        word_t               a;
        word_t               b;
        word_t               sx;
        longint              wide;
        logic                trap_op;
        op   = inst[OP_LSB +: OPCODE_W];
        fn   = inst[FUNC_LSB +: FUNC_W];
        rs   = inst[RS_LSB +: REG_ADDR_W];
        rt   = inst[RT_LSB +: REG_ADDR_W];
        sh   = inst[SHAMT_LSB +: SHAMT_W];
        imm  = inst[IMM_LSB +: IMM_W];
        a    = shadow[rs];
        b    = shadow[rt];
        sx   = {{16{imm[15]}}, imm};
        wen  = 1'b1;
        dst  = rt;
        val  = '0;
        wide = 0;
        trap_op = (op == OP_ADDI) || (op == OP_SPECIAL && (fn == FN_ADD || fn == FN_SUB));
        case (op)
            OP_SPECIAL: begin
                dst = rd_of(inst);
                wen = (sh == '0);
                case (fn)
                    FN_SLL:  val = b << sh;
                    FN_SRL:  val = b >> sh;
                    FN_SRA:  val = $signed(b) >>> sh;
                    FN_SLLV: val = b << a[4:0];
                    FN_SRLV: val = b >> a[4:0];
                    FN_SRAV: val = $signed(b) >>> a[4:0];
                    FN_ADD:  wide = longint'($signed(a)) + longint'($signed(b));
                    FN_SUB:  wide = longint'($signed(a)) - longint'($signed(b));
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_NOR:  val = ~(a | b);
                    FN_SLT:  val = word_t'($signed(a) < $signed(b));
                    FN_SLTU: val = word_t'(a < b);
                    FN_MOVN: begin
                        val = a;
                        wen = wen && (b != '0);
                    end
                    FN_MOVZ: begin
                        val = a;
                        wen = wen && (b == '0);
                    end
                    default: wen = 1'b0;
                endcase
                if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)
                    wen = (rs == '0);   // shamt forms need rs empty
            end
            OP_ORI:   val = a | {16'h0000, imm};
            OP_ANDI:  val = a & {16'h0000, imm};
            OP_XORI:  val = a ^ {16'h0000, imm};
            OP_LUI:   val = {imm, 16'h0000};
            OP_ADDI:  wide = longint'($signed(a)) + longint'($signed(sx));
            OP_ADDIU: val = a + sx;
            OP_SLTI:  val = word_t'($signed(a) < $signed(sx));
            OP_SLTIU: val = word_t'(a < sx);
            default:  wen = 1'b0;
        endcase
        if (trap_op) begin
            val = wide[31:0];
            if (wide != longint'($signed(val)))
                wen = 1'b0;   // result does not fit 32 bits signed
        end
        if (dst == '0)
            wen = 1'b0;
    endfunction

    function automatic reg_addr_t rd_of(input inst_t inst);
        return inst[RD_LSB +: REG_ADDR_W];
    endfunction

    task automatic push_instr(input inst_t inst);
        logic      wen;
        reg_addr_t dst;
        word_t     val;
        predict_write(inst, wen, dst, val);
        if (wen)
            shadow[dst] = val;
        tbl_inst.push_back(inst);
        tbl_strobe.push_back(1'b1);
        tbl_wen.push_back(wen);
        tbl_addr.push_back(dst);
        tbl_data.push_back(val);
    endtask

    // an idle cycle that still carries a writing instruction on the bus
    task automatic insert_bubble();
        tbl_inst.push_back(itype_word(OP_ORI, 1, 0, 16'hdead));
        tbl_strobe.push_back(1'b0);
        tbl_wen.push_back(1'b0);
        tbl_addr.push_back('0);
        tbl_data.push_back('0);
    endtask

    task automatic build_program();
        foreach (shadow[i])
            shadow[i] = '0;
        // constants
        push_instr(itype_word(OP_ORI, 1, 0, $urandom | 32'h8000));   // zero-extended
        push_instr(itype_word(OP_LUI, 2, 0, $urandom));
        push_instr(itype_word(OP_ADDIU, 3, 0, $urandom | 32'h8000)); // sign-extended
        push_instr(itype_word(OP_LUI, 5, 0, 16'h8000));
        push_instr(itype_word(OP_LUI, 6, 0, 16'h7fff));
        push_instr(itype_word(OP_ORI, 6, 6, 16'hffff));
        push_instr(rtype_word(FN_OR, 24, 6, 0));     // newest r6 wins over the execute register
        push_instr(itype_word(OP_ORI, 7, 0, 1));
        push_instr(itype_word(OP_ADDIU, 8, 0, 16'hffff));
        push_instr(itype_word(OP_ORI, 4, 2, $urandom));
        insert_bubble();
        // logic and shifts chained back to back
        push_instr(rtype_word(FN_AND, 9, 1, 3));
        push_instr(rtype_word(FN_OR, 10, 9, 2));
        push_instr(rtype_word(FN_XOR, 11, 9, 10));
        push_instr(rtype_word(FN_NOR, 12, 11, 0));
        push_instr(itype_word(OP_ANDI, 13, 12, $urandom));
        push_instr(itype_word(OP_XORI, 14, 13, $urandom));
        push_instr(shift_word(FN_SLL, 15, 11, ($urandom % 31) + 1));
        push_instr(shift_word(FN_SRL, 16, 8, 4));
        push_instr(shift_word(FN_SRA, 17, 5, 7));
        push_instr(rtype_word(FN_SLLV, 18, 7, 1));
        push_instr(rtype_word(FN_SRLV, 19, 15, 5));
        push_instr(rtype_word(FN_SRAV, 20, 3, 5));
        // r21 three back hits the regfile bypass
        push_instr(itype_word(OP_ORI, 21, 0, $urandom));
        push_instr(itype_word(OP_ORI, 22, 0, $urandom));
        push_instr(itype_word(OP_ORI, 23, 0, $urandom));
        push_instr(rtype_word(FN_OR, 24, 21, 22));
        insert_bubble();
        // arithmetic edges
        push_instr(rtype_word(FN_ADD, 25, 6, 7));    // overflows
        push_instr(rtype_word(FN_ADDU, 25, 6, 7));
        push_instr(rtype_word(FN_SUB, 26, 5, 7));    // overflows
        push_instr(rtype_word(FN_SUBU, 26, 5, 7));
        push_instr(rtype_word(FN_ADD, 27, 8, 7));
        push_instr(rtype_word(FN_SUB, 28, 7, 6));
        push_instr(rtype_word(FN_SLT, 29, 5, 7));
        push_instr(rtype_word(FN_SLTU, 30, 5, 7));
        push_instr(itype_word(OP_SLTI, 29, 8, 0));
        push_instr(itype_word(OP_SLTIU, 30, 7, 16'hffff));
        push_instr(itype_word(OP_ADDI, 31, 6, 1));  // overflows
        push_instr(itype_word(OP_ADDI, 31, 3, $urandom));
        push_instr(rtype_word(FN_ADD, 27, 5, 8));    // negative overflow
        // conditional moves
        push_instr(rtype_word(FN_MOVN, 9, 1, 0));
        push_instr(rtype_word(FN_MOVN, 9, 1, 7));
        push_instr(rtype_word(FN_MOVZ, 10, 2, 0));
        push_instr(rtype_word(FN_MOVZ, 10, 2, 7));
        push_instr(itype_word(OP_ORI, 11, 0, 0));
        push_instr(rtype_word(FN_MOVZ, 12, 6, 11));  // rt straight from execute
        push_instr(rtype_word(FN_MOVN, 13, 6, 11));
        // r0 and unsupported encodings
        push_instr(itype_word(OP_ORI, 0, 0, 16'hffff));
        push_instr(rtype_word(FN_ADD, 0, 1, 2));
        push_instr(rtype_word(6'b011000, 3, 1, 2));                 // mult
        push_instr({6'b011100, 5'd4, 5'd3, 5'd3, 5'd0, 6'b100000}); // clz
        push_instr(rtype_word(6'b001111, 4, 0, 0));                 // sync
        push_instr(rtype_word(FN_OR, 13, 0, 0));
        push_instr(rtype_word(FN_OR, 14, 0, 7));
    endtask

    task automatic check_write(input int row, input reg_addr_t addr, input word_t data);
        if (wb_valid_o !== 1'b1 || wb_addr_o !== addr || wb_data_o !== data) begin
            $display("FAIL %0t: entry %0d (%h) expected r%0d = %h, got valid %b r%0d = %h",
                     $time, row, tbl_inst[row], addr, data, wb_valid_o, wb_addr_o, wb_data_o);
            errors++;
        end else begin
            $display("PASS entry %0d (%h): r%0d = %h", row, tbl_inst[row], addr, data);
        end
    endtask

    task automatic check_no_write(input int row);
        if (wb_valid_o !== 1'b0) begin
            $display("FAIL %0t: entry %0d (%h) expected no write, got valid %b r%0d = %h",
                     $time, row, tbl_inst[row], wb_valid_o, wb_addr_o, wb_data_o);
            errors++;
        end else begin
            $display("PASS entry %0d (%h): no write", row, tbl_inst[row]);
        end
    endtask

    // write port is stable at the falling edge
    always @(negedge clk) begin
        if (!reset_i) begin
            if (pending.size() == 3) begin
                mon_row = pending.pop_front();
                if (mon_row >= 0) begin
                    if (tbl_wen[mon_row])
                        check_write(mon_row, tbl_addr[mon_row], tbl_data[mon_row]);
                    else
                        check_no_write(mon_row);
                    checked++;
                end
            end
            pending.push_back(cur_row);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout reached after %0d cycles, %0d of %0d entries checked",
                     cycles, checked, nrows);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        cur_row      = -1;
        checked      = 0;
        errors       = 0;
        cycles       = 0;
        void'($urandom(32'h64e19311));
        build_program();
        nrows      = tbl_inst.size();
        max_cycles = nrows + 4 + 20;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        for (int i = 0; i < nrows; i++) begin
            @(posedge clk);
            inst_valid_i <= tbl_strobe[i];
            inst_i       <= tbl_inst[i];
            cur_row      <= i;
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        cur_row      <= -1;
        wait (checked == nrows);
        $display("tests %0d, errors %0d", checked, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hw/isa_pkg.sv
hw/uop_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/result_stage.sv
hw/int_pipe_top.sv
verification/int_pipe_tb.sv
